/* logic/i3c_tgt_pkg.sv */
`default_nettype none

package i3c_tgt_pkg;

	//////////////////////////////////////////////////
	// bus constants.
	//////////////////////////////////////////////////

	localparam int I3C_ADDR_W = 7;                                 // target address width.

	localparam logic [I3C_ADDR_W-1:0] I3C_BCAST_ADDR = 7'h7E;      // broadcast address.
	localparam logic [7:0] I3C_CCC_ENTHDR0 = 8'h20;                // enter hdr mode 0 ccc.

	//////////////////////////////////////////////////
	// engine state encoding.
	//////////////////////////////////////////////////

	// shared by both target engines, each walks its own copy.
	typedef enum logic [2:0] {
		IDLE     = 3'd0,   // bus free, waiting for start.
		ADDR     = 3'd1,   // shifting address + rnw.
		ACK      = 3'd2,   // holding sda low for the ack bit.
		DATA     = 3'd3,   // shifting a data or ccc byte.
		PARITY   = 3'd4,   // sampling the t-bit.
		WAIT_END = 3'd5    // not ours, wait for start or stop.
	} eng_st_t;

	//////////////////////////////////////////////////
	// sda requester index.
	//////////////////////////////////////////////////

	// lower index wins in the arbiter.
	typedef enum logic {
		ENG_ENTHDR = 1'b0,   // enthdr detector.
		ENG_PRIV   = 1'b1    // private write receiver.
	} eng_idx_t;

endpackage

`default_nettype wire

/* logic/i3c_bus_cond.sv */
`default_nettype none

module i3c_bus_cond (
	input wire i_sys_clk,
	input wire i_sys_rst,
	input wire i_scl,
	input wire i_sda,
	output logic o_sda_s,
	output logic o_scl_rise,
	output logic o_scl_fall,
	output logic o_start,
	output logic o_stop
);

	//////////////////////////////////////////////////
	// pin synchronizers.
	//////////////////////////////////////////////////

	logic [1:0] scl_sync;   // two flop chain for scl.
	logic [1:0] sda_sync;   // two flop chain for sda.
	logic scl_d;            // previous synced scl.
	logic sda_d;            // previous synced sda.
	logic scl_s;            // synced scl.

	// the bus idles high, so everything resets to one.
	// that keeps a spurious edge from firing right after reset.
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
			scl_d <= 1'b1;
			sda_d <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[0], i_scl};   // shift in the raw pin.
			sda_sync <= {sda_sync[0], i_sda};
			scl_d <= scl_sync[1];               // history for edge compare.
			sda_d <= sda_sync[1];
		end
	end

	assign scl_s = scl_sync[1];
	assign o_sda_s = sda_sync[1];

	//////////////////////////////////////////////////
	// edge and condition pulses.
	//////////////////////////////////////////////////

	assign o_scl_rise = scl_s & ~scl_d;   // one cycle per scl rise.
	assign o_scl_fall = ~scl_s & scl_d;   // one cycle per scl fall.

	// sda moving while scl stays high is a bus condition, not data.
	// a repeated start looks the same as a start here.
	assign o_start = scl_s & scl_d & sda_d & ~o_sda_s;   // sda falls.
	assign o_stop = scl_s & scl_d & ~sda_d & o_sda_s;    // sda rises.

endmodule

`default_nettype wire

/* logic/i3c_enthdr_tgt.sv */
`default_nettype none

module i3c_enthdr_tgt (
	input wire i_sys_clk,
	input wire i_sys_rst,
	input wire i_sda_s,
	input wire i_scl_rise,
	input wire i_scl_fall,
	input wire i_start,
	input wire i_stop,
	input wire i_gnt,
	output logic o_sda_req,
	output logic o_hdr_mode,
	output logic o_parity_err
);

	import i3c_tgt_pkg::*;

	eng_st_t state;        // engine fsm.
	logic [3:0] bit_cnt;   // bits shifted in the current byte.
	logic [7:0] shift_q;   // address + rnw, then the ccc byte.

	//////////////////////////////////////////////////
	// bit shifter.
	//////////////////////////////////////////////////

	// msb first, sampled on the scl rise pulse.
	always_ff @(posedge i_sys_clk)
	begin
		if (i_scl_rise && (state == ADDR || state == DATA))
		begin
			shift_q <= {shift_q[6:0], i_sda_s};
		end
	end

	//////////////////////////////////////////////////
	// control fsm.
	//////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			state <= IDLE;
			bit_cnt <= 4'd0;
			o_sda_req <= 1'b0;
			o_hdr_mode <= 1'b0;
			o_parity_err <= 1'b0;
		end
		else
		begin
			o_parity_err <= 1'b0;   // single cycle pulse.
			if (i_stop)
			begin
				// stop ends the transfer and stands in for the hdr exit pattern.
				state <= IDLE;
				o_sda_req <= 1'b0;
				o_hdr_mode <= 1'b0;
			end
			else if (i_start)
			begin
				state <= ADDR;      // start or repeated start.
				bit_cnt <= 4'd0;
				o_sda_req <= 1'b0;
			end
			else
			begin
				case (state)
				ADDR:
				begin
					if (i_scl_rise && bit_cnt != 4'd8)
					begin
						bit_cnt <= bit_cnt + 4'd1;
					end
					else if (i_scl_fall && bit_cnt == 4'd8)
					begin
						// eighth bit done, only 7E with write is ours.
						if (shift_q == {I3C_BCAST_ADDR, 1'b0})
						begin
							state <= ACK;
							o_sda_req <= 1'b1;   // pull sda for the ack bit.
						end
						else
						begin
							state <= WAIT_END;
						end
					end
				end
				ACK:
				begin
					if (i_scl_rise && !i_gnt)
					begin
						state <= WAIT_END;   // lost the line, counts as nack.
						o_sda_req <= 1'b0;
					end
					else if (i_scl_fall)
					begin
						state <= DATA;       // ack bit over, release sda.
						bit_cnt <= 4'd0;
						o_sda_req <= 1'b0;
					end
				end
				DATA:
				begin
					if (i_scl_rise)
					begin
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt == 4'd7)
						begin
							state <= PARITY;     // ccc byte complete.
							bit_cnt <= 4'd0;
						end
					end
				end
				PARITY:
				begin
					if (i_scl_rise)
					begin
						// t-bit carries odd parity of the ccc byte.
						if (i_sda_s != ~^shift_q)
						begin
							o_parity_err <= 1'b1;
						end
						else if (shift_q == I3C_CCC_ENTHDR0)
						begin
							o_hdr_mode <= 1'b1;   // held until stop.
						end
						state <= WAIT_END;        // other cccs are ignored.
					end
				end
				IDLE, WAIT_END: ;                // only start or stop moves on.
				default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* logic/i3c_priv_wr_tgt.sv */
`default_nettype none

module i3c_priv_wr_tgt #(
	parameter logic [i3c_tgt_pkg::I3C_ADDR_W-1:0] STATIC_ADDR = 7'h2A
) (
	input wire i_sys_clk,
	input wire i_sys_rst,
	input wire i_sda_s,
	input wire i_scl_rise,
	input wire i_scl_fall,
	input wire i_start,
	input wire i_stop,
	input wire i_gnt,
	input wire i_hdr_mode,
	output logic o_sda_req,
	output logic [7:0] o_wr_data,
	output logic o_wr_valid,
	output logic o_parity_err
);

	import i3c_tgt_pkg::*;

	eng_st_t state;        // engine fsm.
	logic [3:0] bit_cnt;   // bits shifted so far.
	logic [7:0] shift_q;   // address + rnw, then each data byte.

	//////////////////////////////////////////////////
	// data path.
	//////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk)
	begin
		if (i_scl_rise && (state == ADDR || state == DATA))
		begin
			shift_q <= {shift_q[6:0], i_sda_s};   // msb first.
		end
		if (i_scl_rise && state == PARITY)
		begin
			o_wr_data <= shift_q;                 // qualified by o_wr_valid.
		end
	end

	//////////////////////////////////////////////////
	// control fsm.
	//////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			state <= IDLE;
			bit_cnt <= 4'd0;
			o_sda_req <= 1'b0;
			o_wr_valid <= 1'b0;
			o_parity_err <= 1'b0;
		end
		else
		begin
			o_wr_valid <= 1'b0;     // pulses, the bus sets the pace.
			o_parity_err <= 1'b0;
			if (i_stop)
			begin
				state <= IDLE;
				o_sda_req <= 1'b0;
			end
			else if (i_start)
			begin
				state <= ADDR;      // a repeated start also ends a write.
				bit_cnt <= 4'd0;
				o_sda_req <= 1'b0;
			end
			else
			begin
				case (state)
				ADDR:
				begin
					if (i_scl_rise && bit_cnt != 4'd8)
					begin
						bit_cnt <= bit_cnt + 4'd1;
					end
					else if (i_scl_fall && bit_cnt == 4'd8)
					begin
						// no sdr ack while the bus is in hdr mode.
						if (shift_q == {STATIC_ADDR, 1'b0} && !i_hdr_mode)
						begin
							state <= ACK;
							o_sda_req <= 1'b1;
						end
						else
						begin
							state <= WAIT_END;
						end
					end
				end
				ACK:
				begin
					if (i_scl_rise && !i_gnt)
					begin
						state <= WAIT_END;   // no grant means nack.
						o_sda_req <= 1'b0;
					end
					else if (i_scl_fall)
					begin
						state <= DATA;
						bit_cnt <= 4'd0;
						o_sda_req <= 1'b0;   // hand sda back to the controller.
					end
				end
				DATA:
				begin
					if (i_scl_rise)
					begin
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt == 4'd7)
						begin
							state <= PARITY;
							bit_cnt <= 4'd0;
						end
					end
				end
				PARITY:
				begin
					if (i_scl_rise)
					begin
						// odd parity check, then straight on to the next byte.
						if (i_sda_s == ~^shift_q)
						begin
							o_wr_valid <= 1'b1;
						end
						else
						begin
							o_parity_err <= 1'b1;   // byte dropped.
						end
						state <= DATA;
					end
				end
				IDLE, WAIT_END: ;
				default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* logic/i3c_sda_arbiter.sv */
`default_nettype none

module i3c_sda_arbiter (
	input wire i_sys_clk,
	input wire i_sys_rst,
	input wire [2**$bits(i3c_tgt_pkg::eng_idx_t)-1:0] i_req,
	output logic [2**$bits(i3c_tgt_pkg::eng_idx_t)-1:0] o_gnt,
	output logic o_sda_oe
);

	import i3c_tgt_pkg::*;

	logic gnt_act_q;       // a grant is held.
	eng_idx_t owner_q;     // who holds it.
	logic gnt_act_nxt;
	eng_idx_t owner_nxt;

	// fixed priority, but only picked when the line is free.
	// the owner keeps it until its request drops.
	always_comb
	begin
		gnt_act_nxt = gnt_act_q;
		owner_nxt = owner_q;
		if (gnt_act_q)
		begin
			gnt_act_nxt = i_req[owner_q];   // release on drop.
		end
		else
		begin
			for (int i = $size(i_req) - 1; i >= 0; i--)
			begin
				if (i_req[i])
				begin
					gnt_act_nxt = 1'b1;
					owner_nxt = eng_idx_t'(i);   // lowest index wins.
				end
			end
		end
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			gnt_act_q <= 1'b0;
			owner_q <= ENG_ENTHDR;
			o_sda_oe <= 1'b0;
		end
		else
		begin
			gnt_act_q <= gnt_act_nxt;
			owner_q <= owner_nxt;
			o_sda_oe <= gnt_act_nxt & i_req[owner_nxt];   // one cycle after request.
		end
	end

	// decode the held grant back to one bit per engine.
	always_comb
	begin
		o_gnt = '0;
		o_gnt[owner_q] = gnt_act_q;
	end

endmodule

`default_nettype wire

/* logic/i3c_tgt_subsys.sv */
`default_nettype none

module i3c_tgt_subsys #(
	parameter logic [i3c_tgt_pkg::I3C_ADDR_W-1:0] STATIC_ADDR = 7'h2A
) (
	input wire i_sys_clk,
	input wire i_sys_rst,
	input wire i_scl,
	input wire i_sda,
	output logic o_sda_oe,
	output logic o_hdr_mode,
	output logic [7:0] o_wr_data,
	output logic o_wr_valid,
	output logic o_parity_err
);

	import i3c_tgt_pkg::*;

	localparam logic PP_OD = 1'b0;   // open-drain only, no push-pull drive.

	logic sda_s, scl_rise, scl_fall, bus_start, bus_stop;
	logic enthdr_req, priv_req;
	logic enthdr_perr, priv_perr;
	logic sda_pull;                  // arbiter pull-down enable.
	logic [2**$bits(eng_idx_t)-1:0] sda_req;
	logic [2**$bits(eng_idx_t)-1:0] sda_gnt;

	//////////////////////////////////////////////////
	// bus front end and engines.
	//////////////////////////////////////////////////

	i3c_bus_cond u_bus_cond (
		.i_sys_clk(i_sys_clk), .i_sys_rst(i_sys_rst), .i_scl(i_scl), .i_sda(i_sda),
		.o_sda_s(sda_s), .o_scl_rise(scl_rise), .o_scl_fall(scl_fall),
		.o_start(bus_start), .o_stop(bus_stop)
	);

	i3c_enthdr_tgt u_enthdr_tgt (
		.i_sys_clk(i_sys_clk), .i_sys_rst(i_sys_rst), .i_sda_s(sda_s),
		.i_scl_rise(scl_rise), .i_scl_fall(scl_fall), .i_start(bus_start),
		.i_stop(bus_stop), .i_gnt(sda_gnt[ENG_ENTHDR]), .o_sda_req(enthdr_req),
		.o_hdr_mode(o_hdr_mode), .o_parity_err(enthdr_perr)
	);

	i3c_priv_wr_tgt #(.STATIC_ADDR(STATIC_ADDR)) u_priv_wr_tgt (
		.i_sys_clk(i_sys_clk), .i_sys_rst(i_sys_rst), .i_sda_s(sda_s),
		.i_scl_rise(scl_rise), .i_scl_fall(scl_fall), .i_start(bus_start),
		.i_stop(bus_stop), .i_gnt(sda_gnt[ENG_PRIV]), .i_hdr_mode(o_hdr_mode),
		.o_sda_req(priv_req), .o_wr_data(o_wr_data), .o_wr_valid(o_wr_valid),
		.o_parity_err(priv_perr)
	);

	//////////////////////////////////////////////////
	// sda sharing.
	//////////////////////////////////////////////////

	assign sda_req[ENG_ENTHDR] = enthdr_req;
	assign sda_req[ENG_PRIV] = priv_req;

	i3c_sda_arbiter u_sda_arbiter (
		.i_sys_clk(i_sys_clk), .i_sys_rst(i_sys_rst), .i_req(sda_req),
		.o_gnt(sda_gnt), .o_sda_oe(sda_pull)
	);

	assign o_sda_oe = sda_pull & ~PP_OD;             // pull low only in open-drain mode.
	assign o_parity_err = enthdr_perr | priv_perr;   // either engine's t-bit error.

endmodule

`default_nettype wire

/* tb/tb_i3c_tgt_subsys.sv */
`default_nettype none

module tb_i3c_tgt_subsys;

	import i3c_tgt_pkg::*;

	// 5 tests of about 40 bits, 20 cycles per bit, plus margin.
	localparam int TIMEOUT_CYC = 6000;

	logic sys_clk, sys_rst;
	logic scl_drv, sda_drv;          // controller side of the bus.
	logic sda_bus;                   // wired-and of controller and target.
	logic sda_oe, hdr_mode, wr_valid, parity_err;
	logic [7:0] wr_data;
	logic [7:0] wr_q [$];            // bytes seen on o_wr_valid.
	int perr_cnt;                    // parity error pulses seen.
	int cyc_cnt = 0;
	integer seed = 45703;
	string cur_test;

	assign sda_bus = sda_drv & ~sda_oe;   // open-drain pull-down.

	i3c_tgt_subsys #(.STATIC_ADDR(7'h2A)) u_i3c_tgt_subsys (
		.i_sys_clk(sys_clk), .i_sys_rst(sys_rst), .i_scl(scl_drv), .i_sda(sda_bus),
		.o_sda_oe(sda_oe), .o_hdr_mode(hdr_mode), .o_wr_data(wr_data),
		.o_wr_valid(wr_valid), .o_parity_err(parity_err)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	//////////////////////////////////////////////////
	// monitors and run limit.
	//////////////////////////////////////////////////

	always @(posedge sys_clk)
	begin
		if (wr_valid)
			wr_q.push_back(wr_data);   // data is registered with valid.
		if (parity_err)
			perr_cnt = perr_cnt + 1;
	end

	always @(posedge sys_clk)
	begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC)
		begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Checks failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("** Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
			$display("Checks failed");
			$fatal(1, "run stopped on first error");
		end
	endtask

	//////////////////////////////////////////////////
	// controller bus model.
	//////////////////////////////////////////////////

	task automatic tick(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// start from idle, or a repeated start when scl is low.
	task automatic start_cond();
		if (scl_drv == 1'b0)
		begin
			tick(5);
			sda_drv <= 1'b1;   // release sda while scl is low.
			tick(5);
			scl_drv <= 1'b1;
		end
		tick(5);
		sda_drv <= 1'b0;       // sda falls with scl high.
		tick(10);
		scl_drv <= 1'b0;
	endtask

	task automatic stop_cond();
		tick(5);
		sda_drv <= 1'b0;
		tick(5);
		scl_drv <= 1'b1;
		tick(10);
		sda_drv <= 1'b1;       // sda rises with scl high.
		tick(10);
	endtask

	// one scl period, half period of 10 cycles, sampled mid-high.
	task automatic drive_bit(input logic b, output logic smp);
		tick(5);
		sda_drv <= b;
		tick(5);
		scl_drv <= 1'b1;
		tick(5);
		smp = sda_bus;         // stable here, target changes sda only with scl low.
		tick(5);
		scl_drv <= 1'b0;
	endtask

	// address + rnw, then the ninth bit released for the target ack.
	task automatic write_addr(input logic [I3C_ADDR_W-1:0] addr, output logic acked);
		logic smp;
		for (int i = I3C_ADDR_W - 1; i >= 0; i--)
			drive_bit(addr[i], smp);
		drive_bit(1'b0, smp);  // write.
		drive_bit(1'b1, smp);
		acked = ~smp;
	endtask

	// data byte msb first, then the t-bit as odd parity.
	task automatic write_byte(input logic [7:0] b, input logic flip_t);
		logic smp;
		for (int i = 7; i >= 0; i--)
			drive_bit(b[i], smp);
		drive_bit(~^b ^ flip_t, smp);
	endtask

	//////////////////////////////////////////////////
	// directed tests.
	//////////////////////////////////////////////////

	task automatic test_enthdr_ok();
		logic acked;
		cur_test = "test_enthdr_ok";
		perr_cnt = 0;
		start_cond();
		write_addr(I3C_BCAST_ADDR, acked);
		check_val("bcast ack", 1, acked);
		write_byte(I3C_CCC_ENTHDR0, 1'b0);
		tick(4);
		check_val("hdr mode", 1, hdr_mode);
		check_val("parity errors", 0, perr_cnt);
		stop_cond();
		check_val("hdr mode after stop", 0, hdr_mode);
	endtask

	task automatic test_enthdr_bad_parity();
		logic acked;
		cur_test = "test_enthdr_bad_parity";
		perr_cnt = 0;
		start_cond();
		write_addr(I3C_BCAST_ADDR, acked);
		check_val("bcast ack", 1, acked);
		write_byte(I3C_CCC_ENTHDR0, 1'b1);   // wrong t-bit.
		tick(4);
		check_val("parity errors", 1, perr_cnt);
		check_val("hdr mode", 0, hdr_mode);
		stop_cond();
	endtask

	task automatic test_priv_write();
		logic acked;
		logic [31:0] rnd;
		logic [7:0] exp_b [0:3];
		cur_test = "test_priv_write";
		perr_cnt = 0;
		wr_q.delete();
		start_cond();
		write_addr(7'h2A, acked);
		check_val("addr ack", 1, acked);
		for (int i = 0; i < 4; i++)
		begin
			rnd = $random(seed);
			exp_b[i] = rnd[7:0];
			write_byte(exp_b[i], 1'b0);
		end
		stop_cond();
		check_val("byte count", 4, wr_q.size());
		for (int i = 0; i < 4 && i < wr_q.size(); i++)
			check_val("data byte", exp_b[i], wr_q[i]);
		check_val("parity errors", 0, perr_cnt);
	endtask

	task automatic test_other_addr();
		logic acked;
		cur_test = "test_other_addr";
		perr_cnt = 0;
		wr_q.delete();
		start_cond();
		write_addr(7'h31, acked);
		check_val("addr ack", 0, acked);   // sda stays high.
		write_byte(8'h5A, 1'b0);           // good t-bit, must not be delivered.
		write_byte(8'hA5, 1'b1);           // bad t-bit, must not be flagged.
		stop_cond();
		check_val("byte count", 0, wr_q.size());
		check_val("parity errors", 0, perr_cnt);
	endtask

	task automatic test_hdr_blocks_priv();
		logic acked;
		cur_test = "test_hdr_blocks_priv";
		perr_cnt = 0;
		wr_q.delete();
		start_cond();
		write_addr(I3C_BCAST_ADDR, acked);
		write_byte(I3C_CCC_ENTHDR0, 1'b0);
		tick(4);
		check_val("hdr mode", 1, hdr_mode);
		start_cond();                      // repeated start to our own address.
		write_addr(7'h2A, acked);
		check_val("ack in hdr", 0, acked);
		check_val("hdr mode held", 1, hdr_mode);
		stop_cond();
		check_val("hdr mode after stop", 0, hdr_mode);
		start_cond();
		write_addr(7'h2A, acked);
		check_val("addr ack", 1, acked);
		write_byte(8'hC5, 1'b0);
		stop_cond();
		check_val("byte count", 1, wr_q.size());
		if (wr_q.size() > 0)
			check_val("data byte", 8'hC5, wr_q[0]);
	endtask

	initial
	begin
		sys_rst = 1'b0;
		scl_drv = 1'b1;        // bus idles high.
		sda_drv = 1'b1;
		perr_cnt = 0;
		cur_test = "reset";
		tick(2);
		sys_rst <= 1'b1;
		tick(5);
		check_val("sda oe", 0, sda_oe);
		check_val("hdr mode", 0, hdr_mode);
		check_val("wr valid", 0, wr_valid);
		check_val("parity err", 0, parity_err);
		test_enthdr_ok();
		test_enthdr_bad_parity();
		test_priv_write();
		test_other_addr();
		test_hdr_blocks_priv();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* i3c_tgt_subsys.f */
logic/i3c_tgt_pkg.sv
logic/i3c_bus_cond.sv
logic/i3c_enthdr_tgt.sv
logic/i3c_priv_wr_tgt.sv
logic/i3c_sda_arbiter.sv
logic/i3c_tgt_subsys.sv
tb/tb_i3c_tgt_subsys.sv
